// File: src.f
bus_pkg.sv
addr_decode.sv
addr_map_regs.sv
bus_demux.sv
periph_mem.sv
periph_bus_top.sv
periph_bus_assert.sv
tb_checker.sv
tb_periph_bus.sv

// File: Makefile
# Verilator build and run for the peripheral bus testbench

VERILATOR  ?= verilator
TOP        ?= tb_periph_bus
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation output holds the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_periph_bus.sv
////////////////////////////////////////////////////////////
// peripheral bus testbench
// seeded random traffic and map rewrites into the DUT,
// responses are checked by tb_checker
////////////////////////////////////////////////////////////

module tb_periph_bus
  import bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          seed_init   = 32'h47573479;
  localparam int unsigned burst_len   = 200;
  localparam int unsigned drain_limit = 16;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        req_valid;
  bus_req_t    req;
  logic        rsp_valid;
  bus_rsp_t    rsp;
  logic        cfg_we;
  logic [1:0]  cfg_rule_sel;
  rule_t       cfg_rule;
  logic        cfg_default_we;
  logic        cfg_default_en;
  idx_t        cfg_default_idx;
  int unsigned err_count;
  int unsigned rsp_count;
  logic        pending;
  int          seed;
  logic        hung;
  int unsigned tests_run;
  int unsigned err_mark;
  int unsigned rsp_mark;

  // 20 ns clock
  always #10 clk = ~clk;

  periph_bus_top UUT (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .req_valid_i       (req_valid),
    .req_i             (req),
    .rsp_valid_o       (rsp_valid),
    .rsp_o             (rsp),
    .cfg_we_i          (cfg_we),
    .cfg_rule_sel_i    (cfg_rule_sel),
    .cfg_rule_i        (cfg_rule),
    .cfg_default_we_i  (cfg_default_we),
    .cfg_default_en_i  (cfg_default_en),
    .cfg_default_idx_i (cfg_default_idx)
  );

  tb_checker i_checker (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .req_valid_i       (req_valid),
    .req_i             (req),
    .cfg_we_i          (cfg_we),
    .cfg_rule_sel_i    (cfg_rule_sel),
    .cfg_rule_i        (cfg_rule),
    .cfg_default_we_i  (cfg_default_we),
    .cfg_default_en_i  (cfg_default_en),
    .cfg_default_idx_i (cfg_default_idx),
    .rsp_valid_i       (rsp_valid),
    .rsp_i             (rsp),
    .err_count_o       (err_count),
    .rsp_count_o       (rsp_count),
    .pending_o         (pending)
  );

  // word address in the first kilobyte, where the rules live
  function automatic addr_t low_addr();
    logic [31:0] r;
    r = $random(seed);
    return {6'h00, r[9:2], 2'b00};
  endfunction

  // word address above every reset rule
  function automatic addr_t miss_addr();
    logic [31:0] r;
    r = $random(seed);
    return {r[15:10] | 6'h01, r[9:2], 2'b00};
  endfunction

  // one request, other strobes low
  task automatic issue(input addr_t addr, input logic we, input data_t wdata);
    @(posedge clk);
    #1;
    req_valid      = 1'b1;
    req            = '{addr: addr, we: we, wdata: wdata};
    cfg_we         = 1'b0;
    cfg_default_we = 1'b0;
  endtask

  task automatic go_idle();
    @(posedge clk);
    #1;
    req_valid      = 1'b0;
    cfg_we         = 1'b0;
    cfg_default_we = 1'b0;
  endtask

  // rule write, with a read on the same edge when asked
  task automatic rewrite_rule(input logic [1:0] sel, input rule_t rule,
                              input logic with_req, input addr_t addr);
    @(posedge clk);
    #1;
    cfg_we         = 1'b1;
    cfg_rule_sel   = sel;
    cfg_rule       = rule;
    cfg_default_we = 1'b0;
    req_valid      = with_req;
    req            = '{addr: addr, we: 1'b0, wdata: '0};
  endtask

  task automatic set_default(input logic en, input idx_t idx);
    @(posedge clk);
    #1;
    cfg_default_we  = 1'b1;
    cfg_default_en  = en;
    cfg_default_idx = idx;
    cfg_we          = 1'b0;
    req_valid       = 1'b0;
  endtask

  // let the last response come back, then report the test
  task automatic finish_test(input string name);
    int unsigned n;
    n = 0;
    go_idle();
    while (pending && n < drain_limit) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (pending) begin
      hung = 1'b1;
      $display("test %s: timeout, responses still outstanding after %0d cycles", name, n);
    end else begin
      $display("test %s: %0d responses, %0d errors", name,
               rsp_count - rsp_mark, err_count - err_mark);
    end
    tests_run++;
    err_mark = err_count;
    rsp_mark = rsp_count;
  endtask

  // write then read back inside each reset rule
  task automatic test_default_ranges();
    addr_t off;
    addr_t a;
    for (int unsigned r = 0; r < no_rules; r++) begin
      for (int unsigned k = 0; k < 2; k++) begin
        off = low_addr();
        // rule 3 spans only 16 bytes
        a = map_reset[r].start_addr | {10'h000, (r == 3) ? {2'b00, off[3:0]} : off[5:0]};
        issue(a, 1'b1, $random(seed));
        issue(a, 1'b0, '0);
      end
    end
    // same word in peripheral 0, the rule 3 range still reads peripheral 1
    issue(16'h0028, 1'b1, $random(seed));
    issue(16'h0128, 1'b0, '0);
    finish_test("default map");
  endtask

  task automatic test_misses();
    logic [31:0] r;
    addr_t       a;
    for (int unsigned k = 0; k < 12; k++) begin
      r = $random(seed);
      a = miss_addr();
      issue(a, r[0], $random(seed));
      // same word in every peripheral, untouched by the miss
      for (int unsigned p = 0; p < no_periphs; p++) begin
        issue(map_reset[p].start_addr | {10'h000, a[5:0]}, 1'b0, '0);
      end
    end
    finish_test("decode miss");
  endtask

  task automatic test_default_idx();
    addr_t a;
    set_default(1'b1, 2'd2);
    for (int unsigned k = 0; k < 6; k++) begin
      a = miss_addr();
      issue(a, 1'b1, $random(seed));
      // same word through rule 2
      issue(16'h0200 | {10'h000, a[5:0]}, 1'b0, '0);
      issue(a, 1'b0, '0);
    end
    set_default(1'b0, 2'd0);
    issue(miss_addr(), 1'b0, '0);
    finish_test("default index");
  endtask

  task automatic test_rewrites();
    logic [31:0] r;
    rule_t       rule;
    addr_t       a;
    for (int unsigned k = 0; k < 10; k++) begin
      r = $random(seed);
      rule.idx        = r[1:0];
      rule.start_addr = {6'h00, r[9:6], 6'h00};
      rule.end_addr   = rule.start_addr + (r[10] ? 16'h0040 : 16'h0020);
      a = rule.start_addr | {12'h000, r[13:12], 2'b00};
      // the read on the write edge decodes with the old map
      rewrite_rule(r[5:4], rule, (k % 2) == 0, a);
      issue(a, 1'b0, '0);
      issue(a, 1'b1, $random(seed));
      issue(low_addr(), r[16], $random(seed));
    end
    finish_test("rule rewrite");
  endtask

  task automatic test_burst();
    logic [31:0] r;
    addr_t       a;
    for (int unsigned k = 0; k < burst_len; k++) begin
      r = $random(seed);
      a = (r[3:1] == 3'd0) ? miss_addr() : low_addr();
      issue(a, r[0], $random(seed));
    end
    finish_test("back-to-back burst");
  endtask

  initial begin
    seed            = seed_init;
    arst_n          = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    cfg_we          = 1'b0;
    cfg_rule_sel    = '0;
    cfg_rule        = '0;
    cfg_default_we  = 1'b0;
    cfg_default_en  = 1'b0;
    cfg_default_idx = '0;
    hung            = 1'b0;
    tests_run       = 0;
    err_mark        = 0;
    rsp_mark        = 0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    if (!hung) test_default_ranges();
    if (!hung) test_misses();
    if (!hung) test_default_idx();
    if (!hung) test_rewrites();
    if (!hung) test_burst();
    $display("%0d tests, %0d responses checked, %0d errors, %0d assertion failures",
             tests_run, rsp_count, err_count, UUT.i_bus_demux.i_bus_assert.fail_cnt);
    if (!hung && err_count == 0 && rsp_count > 0 &&
        UUT.i_bus_demux.i_bus_assert.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb_checker.sv
////////////////////////////////////////////////////////////
// bus checker
// mirrors the address map and the peripheral memories,
// predicts each response and compares it with the DUT
////////////////////////////////////////////////////////////

module tb_checker
  import bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  // master and configuration ports as the DUT sees them
  input  logic        req_valid_i,
  input  bus_req_t    req_i,
  input  logic        cfg_we_i,
  input  logic [1:0]  cfg_rule_sel_i,
  input  rule_t       cfg_rule_i,
  input  logic        cfg_default_we_i,
  input  logic        cfg_default_en_i,
  input  idx_t        cfg_default_idx_i,
  // DUT response
  input  logic        rsp_valid_i,
  input  bus_rsp_t    rsp_i,
  // running totals for the testbench top
  output int unsigned err_count_o,
  output int unsigned rsp_count_o,
  output logic        pending_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // model state
  rule_t       map_m [no_rules];
  logic        def_en_m;
  idx_t        def_idx_m;
  data_t       mem_m [no_periphs][mem_words];
  // prediction for the response due at the next falling edge
  logic        exp_valid = 1'b0;
  bus_rsp_t    exp_rsp;
  idx_t        tgt;
  logic [3:0]  wsel;
  int unsigned err_cnt = 0;
  int unsigned rsp_cnt = 0;

  // peripheral that takes an address, 0 when the request misses
  function automatic logic find_target(input addr_t addr, output idx_t idx);
    logic hit;
    hit = 1'b0;
    idx = '0;
    // later rules override earlier ones
    for (int unsigned i = 0; i < no_rules; i++) begin
      if (addr >= map_m[i].start_addr && addr < map_m[i].end_addr) begin
        hit = 1'b1;
        idx = map_m[i].idx;
      end
    end
    if (!hit && def_en_m) begin
      hit = 1'b1;
      idx = def_idx_m;
    end
    // spare index code has no peripheral
    return hit && (32'(idx) < no_periphs);
  endfunction

  // inputs and outputs are both settled at the falling edge
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < no_rules; i++) begin
        map_m[i] = map_reset[i];
      end
      def_en_m  = default_en_reset;
      def_idx_m = default_idx_reset;
      for (int unsigned p = 0; p < no_periphs; p++) begin
        for (int unsigned w = 0; w < mem_words; w++) begin
          mem_m[p][w] = '0;
        end
      end
      exp_valid = 1'b0;
      exp_rsp   = '0;
    end else begin
      // response to the request accepted at the last rising edge
      if (exp_valid && !rsp_valid_i) begin
        err_cnt++;
        $display("missing response at %0t, a request got no answer", $time);
      end else if (!exp_valid && rsp_valid_i) begin
        err_cnt++;
        $display("unexpected response at %0t with no request before it", $time);
      end else if (exp_valid) begin
        rsp_cnt++;
        if (rsp_i.err !== exp_rsp.err) begin
          err_cnt++;
          $display("mismatch at %0t: rsp_o.err got %b expected %b",
                   $time, rsp_i.err, exp_rsp.err);
        end
        if (rsp_i.rdata !== exp_rsp.rdata) begin
          err_cnt++;
          $display("mismatch at %0t: rsp_o.rdata got %h expected %h",
                   $time, rsp_i.rdata, exp_rsp.rdata);
        end
      end
      // predict the coming request, decoded with the map before any config write
      exp_valid = req_valid_i;
      exp_rsp   = '0;
      if (req_valid_i) begin
        wsel = req_i.addr[5:2];
        if (!find_target(req_i.addr, tgt)) begin
          exp_rsp.err = 1'b1;
        end else if (req_i.we) begin
          mem_m[tgt][wsel] = req_i.wdata;
        end else begin
          exp_rsp.rdata = mem_m[tgt][wsel];
        end
      end
      // config lands at the same edge, seen from the next request on
      if (cfg_we_i) begin
        map_m[cfg_rule_sel_i] = cfg_rule_i;
      end
      if (cfg_default_we_i) begin
        def_en_m  = cfg_default_en_i;
        def_idx_m = cfg_default_idx_i;
      end
    end
  end

  assign err_count_o = err_cnt;
  assign rsp_count_o = rsp_cnt;
  assign pending_o   = exp_valid;

endmodule

// File: periph_bus_assert.sv
////////////////////////////////////////////////////////////
// bus demux assertions
// response timing and error response format, bound to
// every bus_demux instance
////////////////////////////////////////////////////////////

module periph_bus_assert
  import bus_pkg::*;
(
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  req_valid_i,
  input logic [no_periphs-1:0] periph_req_valid_i,
  input logic                  rsp_valid_i,
  input bus_rsp_t              rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failures so far, read by the testbench top
  int unsigned fail_cnt = 0;

  // every request answered on the next cycle
  a_rsp_after_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) req_valid_i |=> rsp_valid_i
  ) else begin
    fail_cnt++;
    $error("no response one cycle after a request");
  end

  // nothing comes back unasked
  a_no_stray_rsp: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) rsp_valid_i |-> $past(req_valid_i)
  ) else begin
    fail_cnt++;
    $error("response without a request the cycle before");
  end

  // err marks exactly the requests no peripheral took, and carries a zero word
  a_err_rsp: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_i |-> (rsp_i.err == !$past(|periph_req_valid_i)) &&
                      (!rsp_i.err || rsp_i.rdata == '0)
  ) else begin
    fail_cnt++;
    $error("error flag or rdata wrong for the request the cycle before");
  end

endmodule

bind bus_demux periph_bus_assert i_bus_assert (
  .clk_i              (clk_i),
  .arst_n_i           (arst_n_i),
  .req_valid_i        (req_valid_i),
  .periph_req_valid_i (periph_req_valid_o),
  .rsp_valid_i        (rsp_valid_o),
  .rsp_i              (rsp_o)
);

// File: periph_bus_top.sv
////////////////////////////////////////////////////////////
// peripheral bus top level
// map registers and decoder select one of three register
// file peripherals per request, misses come back as errors
////////////////////////////////////////////////////////////

module periph_bus_top
  import bus_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // master port
  input  logic                        req_valid_i,
  input  bus_req_t                    req_i,
  output logic                        rsp_valid_o,
  output bus_rsp_t                    rsp_o,
  // configuration port
  input  logic                        cfg_we_i,
  input  logic [$clog2(no_rules)-1:0] cfg_rule_sel_i,
  input  rule_t                       cfg_rule_i,
  input  logic                        cfg_default_we_i,
  input  logic                        cfg_default_en_i,
  input  idx_t                        cfg_default_idx_i
);

  // live map
  rule_t [no_rules-1:0]      addr_map;
  logic                      default_en;
  idx_t                      default_idx;
  // decode of the current request
  idx_t                      dec_idx;
  logic                      dec_error;
  // peripheral side
  logic [no_periphs-1:0]     periph_req_valid;
  bus_req_t                  periph_req;
  logic [no_periphs-1:0]     periph_rsp_valid;
  bus_rsp_t [no_periphs-1:0] periph_rsp;

  addr_map_regs i_map_regs (
    .clk_i,
    .arst_n_i,
    .cfg_we_i,
    .cfg_rule_sel_i,
    .cfg_rule_i,
    .cfg_default_we_i,
    .cfg_default_en_i,
    .cfg_default_idx_i,
    .addr_map_o    (addr_map),
    .default_en_o  (default_en),
    .default_idx_o (default_idx)
  );

  // valid output left open, the demux only needs index and error
  addr_decode i_addr_decode (
    .addr_i           (req_i.addr),
    .addr_map_i       (addr_map),
    .en_default_idx_i (default_en),
    .default_idx_i    (default_idx),
    .idx_o            (dec_idx),
    .dec_valid_o      (),
    .dec_error_o      (dec_error)
  );

  bus_demux i_bus_demux (
    .clk_i,
    .arst_n_i,
    .req_valid_i,
    .req_i,
    .dec_idx_i          (dec_idx),
    .dec_error_i        (dec_error),
    .periph_req_valid_o (periph_req_valid),
    .periph_req_o       (periph_req),
    .periph_rsp_valid_i (periph_rsp_valid),
    .periph_rsp_i       (periph_rsp),
    .rsp_valid_o,
    .rsp_o
  );

  // one register file per index
  for (genvar i = 0; i < no_periphs; i++) begin : gen_periph
    periph_mem i_periph_mem (
      .clk_i,
      .arst_n_i,
      .req_valid_i (periph_req_valid[i]),
      .req_i       (periph_req),
      .rsp_valid_o (periph_rsp_valid[i]),
      .rsp_o       (periph_rsp[i])
    );
  end

endmodule

// File: periph_mem.sv
////////////////////////////////////////////////////////////
// register file peripheral
// word-addressed storage with a registered one-cycle
// response, reads return the word and writes return zero
////////////////////////////////////////////////////////////

module periph_mem
  import bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  // request from the demultiplexer
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  // response one cycle later
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o
);

  // storage
  data_t mem_q [mem_words];
  // selected word, byte offset dropped, rule base ignored
  logic [word_sel_w-1:0] word_sel;
  logic                  rsp_valid_q;
  data_t                 rdata_q;

  assign word_sel = req_i.addr[word_sel_w+1:2];

  // writes land at the request edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < mem_words; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_valid_i && req_i.we) begin
      mem_q[word_sel] <= req_i.wdata;
    end
  end

  // response strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // read data, zero for a write so the master sees a clean word
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= req_i.we ? data_t'(0) : mem_q[word_sel];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  // a peripheral never flags an error
  assign rsp_o       = '{rdata: rdata_q, err: 1'b0};

endmodule

// File: bus_demux.sv
////////////////////////////////////////////////////////////
// bus demultiplexer
// steers each request to the decoded peripheral, answers
// decode misses itself and merges the responses back
////////////////////////////////////////////////////////////

module bus_demux
  import bus_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // master side request
  input  logic                      req_valid_i,
  input  bus_req_t                  req_i,
  // decode result for the current request address
  input  idx_t                      dec_idx_i,
  input  logic                      dec_error_i,
  // peripheral side, request fields are shared
  output logic [no_periphs-1:0]     periph_req_valid_o,
  output bus_req_t                  periph_req_o,
  input  logic [no_periphs-1:0]     periph_rsp_valid_i,
  input  bus_rsp_t [no_periphs-1:0] periph_rsp_i,
  // master side response
  output logic                      rsp_valid_o,
  output bus_rsp_t                  rsp_o
);

  // index with no peripheral behind it
  logic idx_bad;
  // request that no peripheral takes
  logic miss;
  // registered miss, answered one cycle later like a peripheral
  logic err_q;

  // a rule may point at the spare index code, treat that as a miss too
  assign idx_bad = (32'(dec_idx_i) >= no_periphs);
  assign miss    = req_valid_i & (dec_error_i | idx_bad);

  // fields fan out to every peripheral, only the strobe selects
  assign periph_req_o = req_i;

  // one-hot strobe towards the decoded peripheral
  always_comb begin
    for (int unsigned i = 0; i < no_periphs; i++) begin
      periph_req_valid_o[i] = req_valid_i & ~dec_error_i &
                              (dec_idx_i == idx_t'(i));
    end
  end

  // miss flag, one stage like the peripheral response registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= miss;
    end
  end

  // at most one source answers per cycle since one request sits in each stage
  assign rsp_valid_o = err_q | (|periph_rsp_valid_i);

  // response mux
  always_comb begin
    // idle and error value, rdata zero
    rsp_o = '{rdata: '0, err: err_q};
    if (!err_q) begin
      for (int unsigned i = 0; i < no_periphs; i++) begin
        if (periph_rsp_valid_i[i]) begin
          rsp_o = periph_rsp_i[i];
        end
      end
    end
  end

endmodule

// File: addr_map_regs.sv
////////////////////////////////////////////////////////////
// address map registers
// holds the live decode rules and the default index,
// loaded from the package at reset, rewritten per rule
////////////////////////////////////////////////////////////

module addr_map_regs
  import bus_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // rule write port
  input  logic                        cfg_we_i,
  input  logic [$clog2(no_rules)-1:0] cfg_rule_sel_i,
  input  rule_t                       cfg_rule_i,
  // default index write port
  input  logic                        cfg_default_we_i,
  input  logic                        cfg_default_en_i,
  input  idx_t                        cfg_default_idx_i,
  // live map towards the decoder
  output rule_t [no_rules-1:0]        addr_map_o,
  output logic                        default_en_o,
  output idx_t                        default_idx_o
);

  rule_t [no_rules-1:0] map_q;
  logic                 default_en_q;
  idx_t                 default_idx_q;

  // rule flops, one rule replaced per strobe
  // a request on the same edge still decodes with the old rule
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      map_q <= map_reset;
    end else if (cfg_we_i) begin
      map_q[cfg_rule_sel_i] <= cfg_rule_i;
    end
  end

  // default settings, with a strobe of their own
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      default_en_q  <= default_en_reset;
      default_idx_q <= default_idx_reset;
    end else if (cfg_default_we_i) begin
      default_en_q  <= cfg_default_en_i;
      default_idx_q <= cfg_default_idx_i;
    end
  end

  // straight from the flops, no combinational path from the config port
  assign addr_map_o    = map_q;
  assign default_en_o  = default_en_q;
  assign default_idx_o = default_idx_q;

endmodule

// File: addr_decode.sv
////////////////////////////////////////////////////////////
// address decoder
// maps a bus address to a peripheral index over a packed
// array of rules, the highest matching rule wins
////////////////////////////////////////////////////////////

module addr_decode
  import bus_pkg::*;
(
  // address under decode
  input  addr_t                addr_i,
  // live map, the rule at the highest position has priority
  input  rule_t [no_rules-1:0] addr_map_i,
  // default index for addresses without a rule
  input  logic                 en_default_idx_i,
  input  idx_t                 default_idx_i,
  // decode result
  output idx_t                 idx_o,
  output logic                 dec_valid_o,
  output logic                 dec_error_o
);

  // one hit flag per rule
  logic [no_rules-1:0] rule_hit;

  // half-open range compare per rule
  always_comb begin
    for (int unsigned i = 0; i < no_rules; i++) begin
      rule_hit[i] = (addr_i >= addr_map_i[i].start_addr) &&
                    (addr_i <  addr_map_i[i].end_addr);
    end
  end

  // priority pick over the hit flags
  always_comb begin
    // no match, fall back to the default index when it is enabled
    dec_valid_o = 1'b0;
    dec_error_o = ~en_default_idx_i;
    idx_o       = en_default_idx_i ? default_idx_i : idx_t'(0);

    // walk upwards so a later rule overrides an earlier one
    for (int unsigned i = 0; i < no_rules; i++) begin
      if (rule_hit[i]) begin
        dec_valid_o = 1'b1;
        dec_error_o = 1'b0;
        idx_o       = addr_map_i[i].idx;
      end
    end
  end

  // NOTE: a rule with start >= end never hits, so an empty range
  // simply drops out of the map

endmodule

// File: bus_pkg.sv
////////////////////////////////////////////////////////////
// peripheral bus package
// widths, rule and transfer structs, and the address map
// that the rule registers load out of reset
////////////////////////////////////////////////////////////

package bus_pkg;

  // bus widths
  localparam int unsigned addr_w = 16;
  localparam int unsigned data_w = 32;

  // number of address rules held in the map registers
  localparam int unsigned no_rules = 4;
  // peripherals behind the demultiplexer
  localparam int unsigned no_periphs = 3;
  // words in each peripheral register file
  localparam int unsigned mem_words = 16;
  // word select width inside a peripheral, taken from address bits above the byte offset
  localparam int unsigned word_sel_w = $clog2(mem_words);

  // peripheral index, wide enough for one spare code
  typedef logic [1:0] idx_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // one address rule, start included and end excluded
  typedef struct packed {
    idx_t  idx;
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // single-beat request from the master
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  // response, rdata is zero on writes and on errors
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // reset map, listed from rule 3 down to rule 0
  // rule 3 sits inside rule 1 and wins by priority, both select peripheral 1
  localparam rule_t [no_rules-1:0] map_reset = {
    rule_t'{idx: 2'd1, start_addr: 16'h0120, end_addr: 16'h0130},
    rule_t'{idx: 2'd2, start_addr: 16'h0200, end_addr: 16'h0240},
    rule_t'{idx: 2'd1, start_addr: 16'h0100, end_addr: 16'h0140},
    rule_t'{idx: 2'd0, start_addr: 16'h0000, end_addr: 16'h0040}
  };

  // default index is off out of reset, so unmapped addresses give an error
  localparam logic default_en_reset  = 1'b0;
  localparam idx_t default_idx_reset = 2'd0;

endpackage
